// ==== src/sync_params.svh ====
`ifndef SYNC_PARAMS_SVH
`define SYNC_PARAMS_SVH

// Tiles under the tree, two per pair node
`define SYNC_N_TILES 4

// Barrier level, 0 for sibling pair and 1 for all tiles
`define SYNC_LVL_W 1

// Completed global barriers, wraps silently
`define SYNC_CNT_W 16

`endif

// ==== src/sync_pkg.sv ====
package sync_pkg;

  `include "sync_params.svh"

  typedef logic [`SYNC_LVL_W-1:0]   sync_lvl_t;     // Level asked for by a tile
  typedef logic [`SYNC_N_TILES-1:0] tile_vec_t;     // One bit per tile
  typedef logic [`SYNC_CNT_W-1:0]   barrier_cnt_t;  // Global barrier count

  // Level that has to go all the way up to the root
  localparam sync_lvl_t LVL_GLOBAL = sync_lvl_t'(1);

  typedef enum logic [1:0] {
    PAIR_IDLE,        // Waiting for both children
    PAIR_UP_WAIT,     // Forwarded upward, root not done yet
    PAIR_WAKE,        // Children woken, waiting for release
    PAIR_UP_RELEASE   // Up request dropped, root wake still high
  } pair_state_e;

  typedef enum logic {
    ROOT_IDLE,        // Waiting for both pair nodes
    ROOT_WAKE         // Pair nodes woken
  } root_state_e;

endpackage

// ==== src/sync_pair_node.sv ====
`timescale 1ns/1ps

module sync_pair_node (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic [1:0]          req_i,      // One request per child tile
  input  sync_pkg::sync_lvl_t lvl_i [2],  // Held stable while the request is high
  output logic [1:0]          wake_o,     // Doubles as ack for the child
  output logic [1:0]          error_o,    // Level mismatch between siblings
  output logic                up_req_o,   // Global request towards the root
  input  logic                up_wake_i   // Root ack
);

  import sync_pkg::*;

  pair_state_e state_q;
  pair_state_e state_d;
  logic [1:0]  wake_d;
  logic [1:0]  error_d;
  logic        up_req_d;

  logic        both_req;    // Both siblings arrived
  logic        both_rel;    // Both siblings dropped their request
  logic        lvl_diff;    // Siblings disagree on the level
  logic        lvl_global;  // Barrier has to involve the root

  assign both_req   = &req_i;
  assign both_rel   = ~|req_i;
  assign lvl_diff   = lvl_i[0] != lvl_i[1];
  // Only checked when levels match, so child 0 speaks for both
  assign lvl_global = lvl_i[0] == LVL_GLOBAL;

  // Next state and next outputs
  always_comb begin
    state_d  = state_q;
    wake_d   = wake_o;    // Outputs hold by default
    error_d  = error_o;
    up_req_d = up_req_o;
    case (state_q)
      PAIR_IDLE: begin
        if (both_req) begin
          if (lvl_diff) begin
            // Cannot resolve, wake both with error
            wake_d  = 2'b11;
            error_d = 2'b11;
            state_d = PAIR_WAKE;
          end else if (lvl_global) begin
            up_req_d = 1'b1;          // Forward to root
            state_d  = PAIR_UP_WAIT;
          end else begin
            wake_d  = 2'b11;          // Local barrier done
            state_d = PAIR_WAKE;
          end
        end
      end
      PAIR_UP_WAIT: begin
        // Hold up_req until the root answers
        if (up_wake_i) begin
          wake_d  = 2'b11;
          state_d = PAIR_WAKE;
        end
      end
      PAIR_WAKE: begin
        // Back-pressure
        // wake stays high while any child still requests
        if (both_rel) begin
          wake_d   = 2'b00;
          error_d  = 2'b00;
          up_req_d = 1'b0;            // Drops together with the wakes
          if (up_req_o) begin
            state_d = PAIR_UP_RELEASE;
          end else begin
            state_d = PAIR_IDLE;
          end
        end
      end
      PAIR_UP_RELEASE: begin
        // Root must finish its side before a new barrier
        if (!up_wake_i) begin
          state_d = PAIR_IDLE;
        end
      end
      default: begin
        state_d = PAIR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= PAIR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Registered outputs, no glitches towards tiles or root
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wake_o   <= 2'b00;
      error_o  <= 2'b00;
      up_req_o <= 1'b0;
    end else begin
      wake_o   <= wake_d;
      error_o  <= error_d;
      up_req_o <= up_req_d;
    end
  end

endmodule

// ==== src/sync_root_node.sv ====
`timescale 1ns/1ps

module sync_root_node (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic [1:0]             up_req_i,      // One per pair node
  output logic [1:0]             up_wake_o,     // Ack back to each pair node
  output sync_pkg::barrier_cnt_t barrier_cnt_o  // Completed global barriers
);

  import sync_pkg::*;

  root_state_e  state_q;
  root_state_e  state_d;
  logic [1:0]   up_wake_d;
  logic         both_req;   // Both halves of the tree arrived
  logic         both_rel;   // Both halves released
  logic         cnt_en;     // One pulse per global barrier
  barrier_cnt_t cnt_d;

  assign both_req = &up_req_i;
  assign both_rel = ~|up_req_i;

  // Barrier completes on the edge that raises the wakes
  assign cnt_en = (state_q == ROOT_IDLE) && both_req;
  assign cnt_d  = barrier_cnt_o + barrier_cnt_t'(1);

  always_comb begin
    state_d   = state_q;
    up_wake_d = up_wake_o;
    case (state_q)
      ROOT_IDLE: begin
        if (both_req) begin
          up_wake_d = 2'b11;    // Wake both halves at once
          state_d   = ROOT_WAKE;
        end
      end
      ROOT_WAKE: begin
        // Hold until both pair nodes dropped up_req
        if (both_rel) begin
          up_wake_d = 2'b00;
          state_d   = ROOT_IDLE;
        end
      end
      default: begin
        state_d = ROOT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ROOT_IDLE;
      up_wake_o <= 2'b00;
    end else begin
      state_q   <= state_d;
      up_wake_o <= up_wake_d;
    end
  end

  // Global barrier counter
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      barrier_cnt_o <= '0;
    end else if (cnt_en) begin
      barrier_cnt_o <= cnt_d;   // Wraps at full scale
    end
  end

endmodule

// ==== src/sync_tree.sv ====
`timescale 1ns/1ps

`include "sync_params.svh"

module sync_tree (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  sync_pkg::tile_vec_t    sync_req_i,                  // Request per tile
  input  sync_pkg::sync_lvl_t    sync_lvl_i [`SYNC_N_TILES],  // Level per tile
  output sync_pkg::tile_vec_t    wake_o,
  output sync_pkg::tile_vec_t    error_o,
  output sync_pkg::barrier_cnt_t barrier_cnt_o
);

  import sync_pkg::*;

  sync_lvl_t  lvl_lo [2];   // Tiles 0 and 1
  sync_lvl_t  lvl_hi [2];   // Tiles 2 and 3
  logic [1:0] up_req;       // Pair nodes towards root
  logic [1:0] up_wake;      // Root back to pair nodes

  assign lvl_lo[0] = sync_lvl_i[0];
  assign lvl_lo[1] = sync_lvl_i[1];
  assign lvl_hi[0] = sync_lvl_i[2];
  assign lvl_hi[1] = sync_lvl_i[3];

  sync_pair_node i_pair_lo (
    .clk       ( clk              ),
    .arst_n_i  ( arst_n_i         ),
    .req_i     ( sync_req_i[1:0]  ),
    .lvl_i     ( lvl_lo           ),
    .wake_o    ( wake_o[1:0]      ),
    .error_o   ( error_o[1:0]     ),
    .up_req_o  ( up_req[0]        ),
    .up_wake_i ( up_wake[0]       )
  );

  sync_pair_node i_pair_hi (
    .clk       ( clk              ),
    .arst_n_i  ( arst_n_i         ),
    .req_i     ( sync_req_i[3:2]  ),
    .lvl_i     ( lvl_hi           ),
    .wake_o    ( wake_o[3:2]      ),
    .error_o   ( error_o[3:2]     ),
    .up_req_o  ( up_req[1]        ),
    .up_wake_i ( up_wake[1]       )
  );

  sync_root_node i_root (
    .clk           ( clk           ),
    .arst_n_i      ( arst_n_i      ),
    .up_req_i      ( up_req        ),
    .up_wake_o     ( up_wake       ),
    .barrier_cnt_o ( barrier_cnt_o )
  );

endmodule

// ==== test/sync_tree_chk.sv ====
`timescale 1ns/1ps

module sync_tree_chk (
  input logic       clk,
  input logic       arst_n_i,
  input logic [1:0] req_i,      // Child requests
  input logic [1:0] wake_i,     // Child wakes from the node
  input logic [1:0] error_i,    // Child error flags
  input logic       up_req_i,   // Node request to the root
  input logic       up_wake_i   // Root ack
);

  int n_fail = 0;   // Failed assertion count

  // Four-phase rule on the root side
  a_up_req_hold: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    up_req_i && !up_wake_i |=> up_req_i
  ) else begin
    n_fail++;
    $error("up_req_o fell before up_wake_i was seen");
  end

  for (genvar i = 0; i < 2; i++) begin : g_child
    // Wake decided on the edge where the request was seen
    a_wake_needs_req: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      $rose(wake_i[i]) |-> $past(req_i[i])
    ) else begin
      n_fail++;
      $error("wake rose without a request on child %0d", i);
    end

    // Back-pressure
    a_wake_hold: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      wake_i[i] && req_i[i] |=> wake_i[i]
    ) else begin
      n_fail++;
      $error("wake fell while request still high on child %0d", i);
    end

    a_err_with_wake: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      error_i[i] |-> wake_i[i]
    ) else begin
      n_fail++;
      $error("error high without wake on child %0d", i);
    end
  end

endmodule

// ==== test/tb_sync_tree.sv ====
`timescale 1ns/1ps

`include "sync_params.svh"

module tb_sync_tree;

  import sync_pkg::*;

  localparam int N_ROUNDS     = 200;
  localparam int CLK_PERIOD   = 100;
  localparam int ROUND_CYCLES = 30;   // Worst case per round with margin
  localparam int N_T          = `SYNC_N_TILES;

  logic         clk;
  logic         arst_n_i;
  tile_vec_t    sync_req_i;
  sync_lvl_t    sync_lvl_i [N_T];
  tile_vec_t    wake_o;
  tile_vec_t    error_o;
  barrier_cnt_t barrier_cnt_o;

  int   errors;
  int   checks;
  int   assert_fails;     // Failures in both bound checkers
  int   cyc;              // Cycle index, bumped 1 ns after each edge
  int   glob_cnt;         // Model of the root counter
  bit   global_rnd;       // Current round goes through the root
  int   phase    [N_T];   // 0 idle, 1 requesting, 2 woken, 3 dropped, 4 done
  int   delay    [N_T];   // Countdown to raise or drop
  int   req_cyc  [N_T];   // Cycle the request went up, -1 if not yet
  int   drop_cyc [N_T];   // Cycle the request went down, -1 if not yet
  logic exp_err  [N_T];   // Predicted error flag

  sync_tree dut (
    .clk           ( clk           ),
    .arst_n_i      ( arst_n_i      ),
    .sync_req_i    ( sync_req_i    ),
    .sync_lvl_i    ( sync_lvl_i    ),
    .wake_o        ( wake_o        ),
    .error_o       ( error_o       ),
    .barrier_cnt_o ( barrier_cnt_o )
  );

  // Protocol checks in both pair nodes
  bind sync_pair_node sync_tree_chk i_chk (
    .clk       ( clk       ),
    .arst_n_i  ( arst_n_i  ),
    .req_i     ( req_i     ),
    .wake_i    ( wake_o    ),
    .error_i   ( error_o   ),
    .up_req_i  ( up_req_o  ),
    .up_wake_i ( up_wake_i )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(N_ROUNDS * ROUND_CYCLES * CLK_PERIOD);
    $display("timeout: barrier rounds did not complete in the allowed time");
    $display("TB FAILED");
    $finish;
  end

  // Outputs settled, inputs may change
  task automatic step();
    @(posedge clk);
    #1;
    cyc++;
  endtask

  task automatic check_val(input string name, input logic signed [31:0] exp,
                           input logic signed [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  // Cycle on which tile t must see its wake, -1 while a partner is missing
  function automatic int wake_due(input int t);
    int lo;
    int hi;
    int last;
    lo   = global_rnd ? 0 : (t & 2);
    hi   = global_rnd ? N_T - 1 : (t & 2) + 1;
    last = 0;
    for (int i = lo; i <= hi; i++) begin
      if (req_cyc[i] < 0) return -1;
      if (req_cyc[i] > last) last = req_cyc[i];
    end
    return last + (global_rnd ? 3 : 1);   // Root adds two cycles
  endfunction

  task automatic drop_or_count(input int t);
    if (delay[t] == 0) begin
      sync_req_i[t] = 1'b0;
      drop_cyc[t]   = cyc;
      phase[t]      = 3;
    end else begin
      delay[t]--;
    end
  endtask

  task automatic run_round();
    int    due;
    int    sib;
    bit    done;
    string err_name;
    global_rnd = 1'($urandom_range(0, 1));
    for (int t = 0; t < N_T; t += 2) begin
      if (global_rnd) begin
        sync_lvl_i[t]   = sync_lvl_t'(1);
        sync_lvl_i[t+1] = sync_lvl_t'(1);
        exp_err[t]      = 1'b0;
        exp_err[t+1]    = 1'b0;
      end else if ($urandom_range(0, 1) == 1) begin
        sync_lvl_i[t]   = sync_lvl_t'($urandom_range(0, 1));  // Mismatched pair
        sync_lvl_i[t+1] = ~sync_lvl_i[t];
        exp_err[t]      = 1'b1;
        exp_err[t+1]    = 1'b1;
      end else begin
        sync_lvl_i[t]   = sync_lvl_t'(0);
        sync_lvl_i[t+1] = sync_lvl_t'(0);
        exp_err[t]      = 1'b0;
        exp_err[t+1]    = 1'b0;
      end
    end
    for (int t = 0; t < N_T; t++) begin
      phase[t]    = 0;
      delay[t]    = $urandom_range(0, 5);
      req_cyc[t]  = -1;
      drop_cyc[t] = -1;
    end
    if (global_rnd) glob_cnt++;   // Counted before any wake shows
    done = 1'b0;
    while (!done) begin
      step();
      done = 1'b1;
      for (int t = 0; t < N_T; t++) begin
        sib = t ^ 1;
        if (phase[t] == 0) begin
          if (wake_o[t]) flag_error($sformatf("tile %0d woke before its request", t));
          if (delay[t] == 0) begin
            sync_req_i[t] = 1'b1;
            req_cyc[t]    = cyc;
            phase[t]      = 1;
          end else begin
            delay[t]--;
          end
        end else if (phase[t] == 1) begin
          due = wake_due(t);
          if (wake_o[t]) begin
            err_name = global_rnd ? "global_error" : (exp_err[t] ? "mismatch_error" : "pair_error");
            check_val($sformatf("%s tile%0d", global_rnd ? "global_wake_cycle" : "pair_wake_cycle",
                                t), due, cyc);
            check_val($sformatf("%s tile%0d", err_name, t), exp_err[t], error_o[t]);
            check_val($sformatf("barrier_cnt tile%0d", t), glob_cnt, barrier_cnt_o);
            delay[t] = $urandom_range(0, 3);
            phase[t] = 2;
            drop_or_count(t);   // Zero delay drops right away
          end else if (due >= 0 && cyc == due) begin
            flag_error($sformatf("tile %0d not woken on cycle %0d", t, due));
          end
        end else if (phase[t] == 2) begin
          check_val($sformatf("backpressure tile%0d", t), 1, wake_o[t]);   // Request still held
          drop_or_count(t);
        end else if (phase[t] == 3) begin
          if (!wake_o[t]) begin
            // Pair node only releases once both siblings dropped
            if (!(drop_cyc[sib] >= 0 && drop_cyc[sib] < cyc)) begin
              flag_error($sformatf("tile %0d released before tile %0d dropped", t, sib));
            end
            phase[t] = 4;
          end
        end else begin
          if (wake_o[t]) flag_error($sformatf("tile %0d woke again after release", t));
        end
        if (phase[t] != 4) done = 1'b0;
      end
    end
    repeat (3) step();   // Let UP_RELEASE drain back to IDLE
  endtask

  initial begin
    void'($urandom(53));
    errors       = 0;
    checks       = 0;
    assert_fails = 0;
    cyc          = 0;
    glob_cnt     = 0;
    global_rnd   = 1'b0;
    arst_n_i     = 1'b0;
    sync_req_i   = '0;
    for (int t = 0; t < N_T; t++) begin
      sync_lvl_i[t] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    check_val("reset_wake", 0, wake_o);
    check_val("reset_error", 0, error_o);
    check_val("reset_cnt", 0, barrier_cnt_o);
    for (int r = 0; r < N_ROUNDS; r++) begin
      run_round();
    end
    assert_fails = dut.i_pair_lo.i_chk.n_fail + dut.i_pair_hi.i_chk.n_fail;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+src
src/sync_pkg.sv
src/sync_pair_node.sv
src/sync_root_node.sv
src/sync_tree.sv
test/sync_tree_chk.sv
test/tb_sync_tree.sv
